//--- logic/noc_pkg.sv
package noc_pkg;

    // ------------------------------
    // mesh geometry
    // ------------------------------
    localparam int mesh_dim   = 4;
    localparam int coord_w    = 2;
    localparam int node_count = mesh_dim * mesh_dim;
    localparam int port_count = 5;

    // ------------------------------
    // flit layout
    // ------------------------------
    localparam int flit_w    = 64;
    localparam int payload_w = flit_w - 4 * coord_w - 8;

    // port directions, also the index into every per-port array
    // north is toward higher y, east toward higher x
    typedef enum logic [2:0] {
        dir_north = 3'd0,
        dir_south = 3'd1,
        dir_east  = 3'd2,
        dir_west  = 3'd3,
        dir_local = 3'd4
    } dir_t;

    typedef struct packed {
        logic [coord_w-1:0]   dst_x;
        logic [coord_w-1:0]   dst_y;
        logic [coord_w-1:0]   src_x;
        logic [coord_w-1:0]   src_y;
        logic [7:0]           tag;
        logic [payload_w-1:0] payload;
    } flit_t;

    // forward half of a link, ready travels back on its own wire
    typedef struct packed {
        logic  valid;
        flit_t flit;
    } link_t;

endpackage

//--- logic/flit_buffer.sv
`timescale 1ns/1ps

module flit_buffer (
    input  logic           clk,
    input  logic           reset,
    input  logic           load,
    input  noc_pkg::flit_t load_flit,
    input  logic           drain,
    output logic           full,
    output noc_pkg::flit_t head
);
    import noc_pkg::*;

    flit_t data_q;
    logic  full_q;

    // ------------------------------
    // occupancy flag
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (drain) begin
            full_q <= 1'b0;
        end
    end

    // payload register, only written on a load
    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= load_flit;
        end
    end

    assign full = full_q;
    assign head = data_q;

    // ------------------------------
    // checks
    // ------------------------------

    // the sender must have seen ready, so a full entry is never hit
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (reset) !(load && full_q)
    );

    // drain comes from a grant or a link transfer of a held flit
    a_no_empty_drain: assert property (
        @(posedge clk) disable iff (reset) !(drain && !full_q)
    );

endmodule

//--- logic/port_arbiter.sv
`timescale 1ns/1ps

module port_arbiter (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [noc_pkg::port_count-1:0] request,
    input  noc_pkg::flit_t                 candidate [noc_pkg::port_count],
    output logic [noc_pkg::port_count-1:0] grant,
    input  logic                           ready,
    output noc_pkg::link_t                 out_link
);
    import noc_pkg::*;

    dir_t       rr_ptr;
    logic [2:0] win_idx;
    logic       win_found;
    logic       out_full;
    flit_t      out_head;
    logic       send;

    // ------------------------------
    // round-robin pick
    // ------------------------------

    // search starts at rr_ptr and wraps past local back to north
    always_comb begin
        int idx;
        grant     = '0;
        win_found = 1'b0;
        win_idx   = 3'd0;
        for (int off = 0; off < port_count; off++) begin
            idx = int'(rr_ptr) + off;
            if (idx >= port_count) begin
                idx = idx - port_count;
            end
            if (!win_found && request[idx]) begin
                win_found = 1'b1;
                win_idx   = 3'(idx);
            end
        end
        // no new grant while the output register still holds a flit
        if (out_full) begin
            win_found = 1'b0;
        end
        if (win_found) begin
            grant[win_idx] = 1'b1;
        end
    end

    // priority moves to the input just after the winner
    always_ff @(posedge clk) begin
        if (reset) begin
            rr_ptr <= dir_north;
        end else if (win_found) begin
            if (win_idx == 3'(port_count - 1)) begin
                rr_ptr <= dir_north;
            end else begin
                rr_ptr <= dir_t'(win_idx + 3'd1);
            end
        end
    end

    // ------------------------------
    // output register
    // ------------------------------
    flit_buffer i_out_buf (
        .clk       (clk),
        .reset     (reset),
        .load      (win_found),
        .load_flit (candidate[win_idx]),
        .drain     (send),
        .full      (out_full),
        .head      (out_head)
    );

    // ready is a registered level from the receiver, so valid only
    // rises when the far buffer is known to be empty
    assign send           = out_full & ready;
    assign out_link.valid = send;
    assign out_link.flit  = out_head;

    // at most one input may be drained per output each cycle
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(grant)
    );

endmodule

//--- logic/mesh_router.sv
`timescale 1ns/1ps

module mesh_router #(
    parameter int pos_x = 0,
    parameter int pos_y = 0
) (
    input  logic                           clk,
    input  logic                           reset,
    input  noc_pkg::link_t                 in_link   [noc_pkg::port_count],
    output logic [noc_pkg::port_count-1:0] in_ready,
    output noc_pkg::link_t                 out_link  [noc_pkg::port_count],
    input  logic [noc_pkg::port_count-1:0] out_ready
);
    import noc_pkg::*;

    localparam logic [coord_w-1:0] my_x = coord_w'(pos_x);
    localparam logic [coord_w-1:0] my_y = coord_w'(pos_y);

    // sides with a neighbour, bit order follows dir_t
    localparam logic [port_count-1:0] side_present = {
        1'b1,
        1'(pos_x > 0),
        1'(pos_x < mesh_dim - 1),
        1'(pos_y > 0),
        1'(pos_y < mesh_dim - 1)
    };

    logic [port_count-1:0] in_full;
    flit_t                 in_head      [port_count];
    dir_t                  route        [port_count];
    logic [port_count-1:0] req_by_out   [port_count];
    logic [port_count-1:0] grant_by_out [port_count];
    logic [port_count-1:0] req_any;
    logic [port_count-1:0] in_drain;

    // ------------------------------
    // input buffers
    // ------------------------------
    for (genvar i = 0; i < port_count; i++) begin : g_in
        if (side_present[i]) begin : g_buf
            flit_buffer i_in_buf (
                .clk       (clk),
                .reset     (reset),
                .load      (in_link[i].valid),
                .load_flit (in_link[i].flit),
                .drain     (in_drain[i]),
                .full      (in_full[i]),
                .head      (in_head[i])
            );
        end else begin : g_edge
            assign in_full[i] = 1'b0;
            assign in_head[i] = '0;

            // the top level loops our own idle output back into this port
            a_edge_idle: assert property (
                @(posedge clk) disable iff (reset) !in_link[i].valid
            );
        end
        assign in_ready[i] = ~in_full[i];
    end

    // ------------------------------
    // XY route decode
    // ------------------------------
    always_comb begin
        for (int i = 0; i < port_count; i++) begin
            if (in_head[i].dst_x > my_x) begin
                route[i] = dir_east;
            end else if (in_head[i].dst_x < my_x) begin
                route[i] = dir_west;
            end else if (in_head[i].dst_y > my_y) begin
                route[i] = dir_north;
            end else if (in_head[i].dst_y < my_y) begin
                route[i] = dir_south;
            end else begin
                route[i] = dir_local;
            end
        end
    end

    // request matrix, indexed [output][input]
    always_comb begin
        for (int o = 0; o < port_count; o++) begin
            for (int i = 0; i < port_count; i++) begin
                req_by_out[o][i] = in_full[i] && (int'(route[i]) == o);
            end
            req_any[o] = |req_by_out[o];
        end
    end

    // ------------------------------
    // output arbiters
    // ------------------------------

    // requests to a missing side are masked, so that output stays idle
    for (genvar o = 0; o < port_count; o++) begin : g_out
        port_arbiter i_arb (
            .clk       (clk),
            .reset     (reset),
            .request   (req_by_out[o] & {port_count{side_present[o]}}),
            .candidate (in_head),
            .grant     (grant_by_out[o]),
            .ready     (out_ready[o]),
            .out_link  (out_link[o])
        );
    end

    // an input drains when any output takes its flit
    always_comb begin
        in_drain = '0;
        for (int o = 0; o < port_count; o++) begin
            in_drain = in_drain | grant_by_out[o];
        end
    end

    // destinations inside the mesh never send XY routing off an edge
    a_no_off_mesh: assert property (
        @(posedge clk) disable iff (reset) (req_any & ~side_present) == '0
    );

endmodule

//--- logic/mesh_noc.sv
`timescale 1ns/1ps

module mesh_noc (
    input  logic                           clk,
    input  logic                           reset,
    input  noc_pkg::link_t                 pe_in [noc_pkg::node_count],
    output logic [noc_pkg::node_count-1:0] pe_in_ready,
    output noc_pkg::link_t                 pe_out [noc_pkg::node_count],
    input  logic [noc_pkg::node_count-1:0] pe_out_ready
);
    import noc_pkg::*;

    // per-router port bundles, node index is y * mesh_dim + x
    link_t                 r_in        [node_count][port_count];
    link_t                 r_out       [node_count][port_count];
    logic [port_count-1:0] r_in_ready  [node_count];
    logic [port_count-1:0] r_out_ready [node_count];

    for (genvar y = 0; y < mesh_dim; y++) begin : g_row
        for (genvar x = 0; x < mesh_dim; x++) begin : g_col
            localparam int n = y * mesh_dim + x;

            mesh_router #(
                .pos_x (x),
                .pos_y (y)
            ) i_router (
                .clk       (clk),
                .reset     (reset),
                .in_link   (r_in[n]),
                .in_ready  (r_in_ready[n]),
                .out_link  (r_out[n]),
                .out_ready (r_out_ready[n])
            );

            // ------------------------------
            // local processing element
            // ------------------------------
            assign r_in[n][dir_local]        = pe_in[n];
            assign pe_in_ready[n]            = r_in_ready[n][dir_local];
            assign pe_out[n]                 = r_out[n][dir_local];
            assign r_out_ready[n][dir_local] = pe_out_ready[n];

            // ------------------------------
            // horizontal neighbours
            // ------------------------------
            if (x < mesh_dim - 1) begin : g_east
                assign r_in[n][dir_east]        = r_out[n + 1][dir_west];
                assign r_out_ready[n][dir_east] = r_in_ready[n + 1][dir_west];
            end else begin : g_east_edge
                // right column loops its idle east output onto itself
                assign r_in[n][dir_east]        = r_out[n][dir_east];
                assign r_out_ready[n][dir_east] = r_in_ready[n][dir_east];
            end

            if (x > 0) begin : g_west
                assign r_in[n][dir_west]        = r_out[n - 1][dir_east];
                assign r_out_ready[n][dir_west] = r_in_ready[n - 1][dir_east];
            end else begin : g_west_edge
                assign r_in[n][dir_west]        = r_out[n][dir_west];
                assign r_out_ready[n][dir_west] = r_in_ready[n][dir_west];
            end

            // ------------------------------
            // vertical neighbours
            // ------------------------------
            if (y < mesh_dim - 1) begin : g_north
                assign r_in[n][dir_north]        = r_out[n + mesh_dim][dir_south];
                assign r_out_ready[n][dir_north] = r_in_ready[n + mesh_dim][dir_south];
            end else begin : g_north_edge
                // top row, nothing above
                assign r_in[n][dir_north]        = r_out[n][dir_north];
                assign r_out_ready[n][dir_north] = r_in_ready[n][dir_north];
            end

            if (y > 0) begin : g_south
                assign r_in[n][dir_south]        = r_out[n - mesh_dim][dir_north];
                assign r_out_ready[n][dir_south] = r_in_ready[n - mesh_dim][dir_north];
            end else begin : g_south_edge
                assign r_in[n][dir_south]        = r_out[n][dir_south];
                assign r_out_ready[n][dir_south] = r_in_ready[n][dir_south];
            end
        end
    end

endmodule

//--- sim/noc_model.svh
`ifndef noc_model_svh
`define noc_model_svh

    // ------------------------------
    // reference model
    // ------------------------------

    // flits in flight per destination and source with the oldest at the front
    flit_t expected_q [node_count][node_count][$];

    function automatic int node_of(logic [coord_w-1:0] x, logic [coord_w-1:0] y);
        return int'(y) * mesh_dim + int'(x);
    endfunction

    // XY routing gives one path per pair, so each queue keeps send order
    function automatic void expect_flit(flit_t f);
        expected_q[node_of(f.dst_x, f.dst_y)][node_of(f.src_x, f.src_y)].push_back(f);
    endfunction

    // returns 0 when nothing is pending for this pair
    function automatic logic take_expected(int dst, int src, output flit_t f);
        if (expected_q[dst][src].size() == 0) begin
            f = '0;
            return 1'b0;
        end
        f = expected_q[dst][src].pop_front();
        return 1'b1;
    endfunction

    function automatic int pending_for(int dst);
        int total;
        total = 0;
        for (int s = 0; s < node_count; s++) begin
            total += expected_q[dst][s].size();
        end
        return total;
    endfunction

    function automatic int pending_count();
        int total;
        total = 0;
        for (int d = 0; d < node_count; d++) begin
            total += pending_for(d);
        end
        return total;
    endfunction

`endif

//--- sim/mesh_noc_tb.sv
`timescale 1ns/1ps

module mesh_noc_tb;
    import noc_pkg::*;

    localparam int     clk_period   = 8;
    localparam int     reset_cycles = 4;
    localparam int     mix_flits    = 20;
    localparam int     hold_flits   = 8;
    localparam int     hot_flits    = 6;
    localparam int     total_flits  = node_count * (mix_flits + hold_flits + hot_flits);
    localparam longint watchdog_ns  = longint'(total_flits) * 200 * clk_period;
    localparam int     hold_node    = 5;
    localparam int     hold_cycles  = 160;
    localparam int     hot_node     = 0;

    logic                  clk;
    logic                  reset;
    link_t                 pe_in  [node_count];
    logic [node_count-1:0] pe_in_ready;
    link_t                 pe_out [node_count];
    logic [node_count-1:0] pe_out_ready;

    logic [7:0] tag_next [node_count];
    int         self_seen;

    `include "noc_model.svh"

    mesh_noc i_mesh_noc (
        .clk          (clk),
        .reset        (reset),
        .pe_in        (pe_in),
        .pe_in_ready  (pe_in_ready),
        .pe_out       (pe_out),
        .pe_out_ready (pe_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ------------------------------
    // error reporting and checks
    // ------------------------------
    task automatic report_mismatch(string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_flit(flit_t got, flit_t exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %h, expected %h", what, got, exp));
        end
    endtask

    // an ejected flit must be the oldest one pending for its pair
    task automatic check_flit(int node, flit_t got);
        flit_t exp;
        int    src;
        src = node_of(got.src_x, got.src_y);
        if (!take_expected(node, src, exp)) begin
            report_mismatch($sformatf("node %0d ejected %h, none pending from %0d",
                                      node, got, src));
        end
        if (src == node) begin
            self_seen++;
        end
        compare_flit(got, exp, $sformatf("flit at node %0d from node %0d", node, src));
    endtask

    task automatic check_ready(logic got, logic exp, string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic check_idle(string when);
        for (int n = 0; n < node_count; n++) begin
            check_ready(pe_in_ready[n], 1'b1, $sformatf("pe_in_ready[%0d] %s", n, when));
            check_ready(pe_out[n].valid, 1'b0, $sformatf("pe_out[%0d] valid %s", n, when));
        end
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------
    function automatic int pick_dest(int src, int hot, int hot_pct);
        if (hot >= 0 && int'($urandom % 100) < hot_pct) begin
            return hot;
        end
        if (($urandom % 8) == 0) begin
            return src;
        end
        return int'($urandom % node_count);
    endfunction

    function automatic flit_t make_flit(int src, int dst, logic [7:0] tag);
        flit_t f;
        f.dst_x   = coord_w'(dst % mesh_dim);
        f.dst_y   = coord_w'(dst / mesh_dim);
        f.src_x   = coord_w'(src % mesh_dim);
        f.src_y   = coord_w'(src / mesh_dim);
        f.tag     = tag;
        f.payload = payload_w'({$urandom, $urandom});
        return f;
    endfunction

    // one traffic phase that returns once every flit of it has been ejected
    task automatic run_phase(int per_node, int hot, int hot_pct, int hold);
        int                    to_send [node_count];
        logic [node_count-1:0] sent;
        int                    unsent;
        int                    cyc;
        int                    src;
        flit_t                 f;
        flit_t                 parked;
        sent   = '0;
        unsent = node_count * per_node;
        cyc    = 0;
        parked = '0;
        for (int n = 0; n < node_count; n++) begin
            to_send[n] = per_node;
        end
        while (unsent > 0 || pending_count() > 0) begin
            @(negedge clk);
            for (int n = 0; n < node_count; n++) begin
                // last cycle's flit now sits in the input buffer
                if (sent[n]) begin
                    check_ready(pe_in_ready[n], 1'b0, $sformatf("pe_in_ready[%0d] after send", n));
                end
                sent[n]  = 1'b0;
                pe_in[n] = '0;
                if (to_send[n] > 0 && pe_in_ready[n] && ($urandom % 3) != 0) begin
                    f = make_flit(n, pick_dest(n, hot, hot_pct), tag_next[n]);
                    tag_next[n] = tag_next[n] + 8'd1;
                    expect_flit(f);
                    pe_in[n].valid = 1'b1;
                    pe_in[n].flit  = f;
                    sent[n]        = 1'b1;
                    to_send[n]--;
                    unsent--;
                end
                if (n == hold && cyc < hold_cycles) begin
                    pe_out_ready[n] = 1'b0;
                end else begin
                    pe_out_ready[n] = ($urandom % 4) != 0;
                end
            end
            #1;
            for (int n = 0; n < node_count; n++) begin
                if (pe_out[n].valid) begin
                    check_flit(n, pe_out[n].flit);
                end
            end
            // held output must keep its flit parked
            if (hold >= 0 && cyc < hold_cycles) begin
                check_ready(pe_out[hold].valid, 1'b0, "pe_out valid while ready held low");
                if (cyc == hold_cycles / 2) begin
                    if (pending_for(hold) == 0) begin
                        report_failure("no traffic reached the held node during the hold");
                    end
                    parked = pe_out[hold].flit;
                    // the parked flit is the oldest one still owed from its source
                    src = node_of(parked.src_x, parked.src_y);
                    if (expected_q[hold][src].size() == 0) begin
                        report_failure("the flit parked at the held output was never sent there");
                    end
                    compare_flit(parked, expected_q[hold][src][0],
                                 "oldest flit owed to the held output");
                end else if (cyc > hold_cycles / 2) begin
                    compare_flit(pe_out[hold].flit, parked, "flit parked at the held output");
                end
            end
            cyc++;
        end
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        #(watchdog_ns);
        report_failure("watchdog expired, flit delivery did not finish in time");
    end

    initial begin
        void'($urandom(32'h2d86_2874));
        reset        = 1'b1;
        pe_out_ready = '1;
        self_seen    = 0;
        for (int n = 0; n < node_count; n++) begin
            pe_in[n]    = '0;
            tag_next[n] = 8'd0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_idle("right after reset");

        run_phase(mix_flits, -1, 0, -1);
        @(negedge clk);
        check_idle("after mixed traffic");

        run_phase(hold_flits, hold_node, 50, hold_node);
        @(negedge clk);
        check_idle("after the held output");

        // all-to-one toward the bottom left corner
        run_phase(hot_flits, hot_node, 100, -1);
        @(negedge clk);
        check_idle("after hot spot traffic");

        if (self_seen == 0) begin
            report_failure("no flit addressed to its own source was ejected");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

//--- vlog.f
+incdir+sim
logic/noc_pkg.sv
logic/flit_buffer.sv
logic/port_arbiter.sv
logic/mesh_router.sv
logic/mesh_noc.sv
sim/mesh_noc_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the mesh NoC testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f vlog.f --top-module mesh_noc_tb -Mdir obj_dir -o mesh_noc_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/mesh_noc_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
